// File: cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 6;    // 64-byte line
    localparam int SET_W    = 6;    // 64 sets
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;
    localparam int BANK_NUM = 8;
    localparam int WAY_NUM  = 2;
    localparam int WORD_W   = 64;
    localparam int LINE_W   = WORD_W * BANK_NUM;

    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [SET_W-1:0]            set_idx_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [$clog2(BANK_NUM)-1:0] bank_idx_t;  // addr bits 5..3
    typedef logic [WORD_W-1:0]           word_t;

    // bitwise write mask, a set bit means the data bit is written
    typedef logic [WORD_W-1:0]           mask_t;

    typedef logic [LINE_W-1:0]           line_t;      // bank 0 in the low bits
    typedef logic [WAY_NUM-1:0]          way_oh_t;
    typedef logic [BANK_NUM-1:0]         bank_oh_t;

endpackage

// File: cache_bus_pkg.sv
package cache_bus_pkg;

    localparam int OP_W = 1;    // core and memory bus only know read and write

    typedef enum logic [OP_W-1:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

endpackage

// File: dcache_tag_array.sv
module dcache_tag_array (
    input  logic                                   clock,
    input  logic                                   reset_n,
    input  logic                                   rd_en,
    input  cache_geom_pkg::set_idx_t               rd_set,
    input  logic                                   wr_en,
    input  cache_geom_pkg::set_idx_t               wr_set,
    input  cache_geom_pkg::way_oh_t                wr_way,
    input  cache_geom_pkg::tag_t                   wr_tag,
    input  logic                                   wr_dirty,
    output logic [cache_geom_pkg::WAY_NUM-1:0]     rd_valid,
    output logic [cache_geom_pkg::WAY_NUM-1:0]     rd_dirty,
    output cache_geom_pkg::tag_t                   rd_tag0,
    output cache_geom_pkg::tag_t                   rd_tag1
);
    localparam int SETS = 1 << cache_geom_pkg::SET_W;

    logic [cache_geom_pkg::WAY_NUM-1:0] valid_q [SETS];
    logic [cache_geom_pkg::WAY_NUM-1:0] dirty_q [SETS];
    cache_geom_pkg::tag_t               tag0_q  [SETS];
    cache_geom_pkg::tag_t               tag1_q  [SETS];

    // reset invalidates every way of every set
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
            rd_valid <= '0;
        end else begin
            if (wr_en) begin
                valid_q[wr_set] <= valid_q[wr_set] | wr_way;
            end
            if (rd_en) begin
                rd_valid <= valid_q[rd_set];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en && wr_way[0]) begin
            tag0_q[wr_set]     <= wr_tag;
            dirty_q[wr_set][0] <= wr_dirty;
        end
        if (wr_en && wr_way[1]) begin
            tag1_q[wr_set]     <= wr_tag;
            dirty_q[wr_set][1] <= wr_dirty;
        end
        if (rd_en) begin        // both ways at once
            rd_dirty <= dirty_q[rd_set];
            rd_tag0  <= tag0_q[rd_set];
            rd_tag1  <= tag1_q[rd_set];
        end
    end

endmodule

// File: dcache_data_array.sv
module dcache_data_array (
    input  logic                     clock,
    input  logic                     rd_en,
    input  cache_geom_pkg::set_idx_t rd_set,
    input  cache_geom_pkg::way_oh_t  rd_way,
    input  logic                     wr_en,
    input  cache_geom_pkg::set_idx_t wr_set,
    input  cache_geom_pkg::way_oh_t  wr_way,
    input  cache_geom_pkg::line_t    wr_line,
    input  cache_geom_pkg::line_t    wr_mask_line,
    output cache_geom_pkg::line_t    rd_line
);
    localparam int SETS  = 1 << cache_geom_pkg::SET_W;
    localparam int WAYS  = cache_geom_pkg::WAY_NUM;
    localparam int BANKS = cache_geom_pkg::BANK_NUM;
    localparam int W     = cache_geom_pkg::WORD_W;

    cache_geom_pkg::word_t mem_q [SETS][WAYS][BANKS];

    // masked write per bank; a refill just passes an all-ones mask
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (wr_way[w]) begin
                    for (int b = 0; b < BANKS; b++) begin
                        mem_q[wr_set][w][b] <=
                            (wr_line[b*W +: W] & wr_mask_line[b*W +: W]) |
                            (mem_q[wr_set][w][b] & ~wr_mask_line[b*W +: W]);
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (rd_way[w]) begin    // one-hot, at most one match
                    for (int b = 0; b < BANKS; b++) begin
                        rd_line[b*W +: W] <= mem_q[rd_set][w][b];
                    end
                end
            end
        end
    end

endmodule

// File: dcache_lookup.sv
module dcache_lookup (
    input  logic                               clock,
    input  logic                               reset_n,
    input  cache_geom_pkg::tag_t               req_tag,
    input  cache_geom_pkg::set_idx_t           req_set,
    input  logic [cache_geom_pkg::WAY_NUM-1:0] rd_valid,
    input  logic [cache_geom_pkg::WAY_NUM-1:0] rd_dirty,
    input  cache_geom_pkg::tag_t               rd_tag0,
    input  cache_geom_pkg::tag_t               rd_tag1,
    output logic                               hit,
    output cache_geom_pkg::way_oh_t            hit_way,
    output cache_geom_pkg::way_oh_t            victim_way,
    output logic                               victim_dirty,
    output cache_geom_pkg::addr_t              victim_addr
);
    logic [7:0]           lfsr_q;
    cache_geom_pkg::tag_t victim_tag;

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr_q <= 8'hff;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign hit_way[0] = rd_valid[0] && (rd_tag0 == req_tag);
    assign hit_way[1] = rd_valid[1] && (rd_tag1 == req_tag);
    assign hit        = |hit_way;

    // invalid way first, then a clean one, then random
    always_comb begin
        if (!rd_valid[0]) begin
            victim_way = 2'b01;
        end else if (!rd_valid[1]) begin
            victim_way = 2'b10;
        end else if (!rd_dirty[0]) begin
            victim_way = 2'b01;
        end else if (!rd_dirty[1]) begin
            victim_way = 2'b10;
        end else begin
            victim_way = {lfsr_q[0], ~lfsr_q[0]};
        end
    end

    assign victim_dirty = |(victim_way & rd_valid & rd_dirty);
    assign victim_tag   = victim_way[1] ? rd_tag1 : rd_tag0;

    // line address of the victim for write-back
    assign victim_addr  = {victim_tag, req_set, {cache_geom_pkg::OFFSET_W{1'b0}}};

endmodule

// File: dcache_mem_port.sv
module dcache_mem_port (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      start,
    input  cache_bus_pkg::op_t        op,
    input  cache_geom_pkg::addr_t     line_addr,
    input  cache_geom_pkg::line_t     wb_line,
    input  cache_geom_pkg::bank_idx_t store_bank,
    input  cache_geom_pkg::word_t     store_data,
    input  cache_geom_pkg::mask_t     store_mask,
    input  logic                      is_store,
    input  logic                      mem_ready,
    input  logic                      mem_done,
    input  cache_geom_pkg::line_t     mem_rdata,
    output logic                      mem_valid,
    output cache_bus_pkg::op_t        mem_op,
    output cache_geom_pkg::addr_t     mem_addr,
    output cache_geom_pkg::line_t     mem_wdata,
    output logic                      line_done,
    output cache_geom_pkg::line_t     refill_line
);
    localparam int W = cache_geom_pkg::WORD_W;

    cache_geom_pkg::line_t merged;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_valid <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= mem_done;
            if (start) begin
                mem_valid <= 1'b1;
            end else if (mem_ready) begin   // accepted, drop next cycle
                mem_valid <= 1'b0;
            end
        end
    end

    // store miss: fold the store word into the fetched line
    always_comb begin
        merged = mem_rdata;
        if (is_store) begin
            merged[store_bank*W +: W] = (store_data & store_mask) |
                                        (mem_rdata[store_bank*W +: W] & ~store_mask);
        end
    end

    // request fields stay put while mem_valid waits for mem_ready
    always_ff @(posedge clock) begin
        if (start) begin
            mem_op    <= op;
            mem_addr  <= line_addr;
            mem_wdata <= (op == cache_bus_pkg::OP_WRITE) ? wb_line : '0;
        end
        if (mem_done) begin
            refill_line <= merged;
        end
    end

endmodule

// File: dcache_ctrl.sv
module dcache_ctrl (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      req_valid,
    input  cache_bus_pkg::op_t        req_op,
    input  cache_geom_pkg::addr_t     req_addr,
    input  cache_geom_pkg::word_t     req_wdata,
    input  cache_geom_pkg::mask_t     req_wmask,
    output logic                      req_ready,
    output logic                      resp_done,
    output cache_geom_pkg::word_t     resp_rdata,
    input  logic                      hit,
    input  cache_geom_pkg::way_oh_t   hit_way,
    input  cache_geom_pkg::way_oh_t   victim_way,
    input  logic                      victim_dirty,
    input  cache_geom_pkg::addr_t     victim_addr,
    output cache_geom_pkg::tag_t      req_tag,
    output cache_geom_pkg::set_idx_t  req_set,
    output logic                      tag_rd_en,
    output cache_geom_pkg::set_idx_t  tag_rd_set,
    output logic                      arr_wr_en,
    output cache_geom_pkg::way_oh_t   arr_wr_way,
    output logic                      tag_wr_dirty,
    output logic                      data_rd_en,
    output cache_geom_pkg::way_oh_t   data_rd_way,
    output cache_geom_pkg::line_t     data_wr_line,
    output cache_geom_pkg::line_t     data_wr_mask,
    input  cache_geom_pkg::line_t     rd_line,
    output logic                      mem_start,
    output cache_bus_pkg::op_t        mem_req_op,
    output cache_geom_pkg::addr_t     line_addr,
    output cache_geom_pkg::line_t     wb_line,
    output cache_geom_pkg::bank_idx_t store_bank,
    output cache_geom_pkg::word_t     store_data,
    output cache_geom_pkg::mask_t     store_mask,
    output logic                      is_store,
    input  logic                      line_done,
    input  cache_geom_pkg::line_t     refill_line
);
    localparam int W = cache_geom_pkg::WORD_W;
    localparam int OFS = cache_geom_pkg::OFFSET_W;

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_WRITE_HIT, S_READ_HIT,
        S_READ_VICTIM, S_WRITE_BACK, S_REFILL, S_RESPOND
    } state_t;

    state_t                   state_q, state_d;
    cache_geom_pkg::addr_t    addr_q, victim_addr_q;
    cache_bus_pkg::op_t       op_q;
    cache_geom_pkg::word_t    wdata_q, resp_q;
    cache_geom_pkg::mask_t    wmask_q;
    cache_geom_pkg::way_oh_t  way_q;
    cache_geom_pkg::bank_oh_t bank_oh;
    cache_geom_pkg::line_t    hit_mask;
    logic                     fire;

    assign fire       = req_valid && req_ready;
    assign req_ready  = (state_q == S_IDLE);
    assign resp_done  = (state_q == S_RESPOND);
    assign resp_rdata = (resp_done && op_q == cache_bus_pkg::OP_READ) ? resp_q : '0;

    assign req_tag    = addr_q[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::TAG_W];
    assign req_set    = addr_q[OFS +: cache_geom_pkg::SET_W];
    assign store_bank = addr_q[OFS-1:3];
    assign store_data = wdata_q;
    assign store_mask = wmask_q;
    assign is_store   = (op_q == cache_bus_pkg::OP_WRITE);

    always_comb begin
        case (state_q)
            S_IDLE:        state_d = fire ? S_LOOKUP : S_IDLE;
            S_LOOKUP:      state_d = hit ? (is_store ? S_WRITE_HIT : S_READ_HIT)
                                         : (victim_dirty ? S_READ_VICTIM : S_REFILL);
            S_WRITE_HIT:   state_d = S_RESPOND;
            S_READ_HIT:    state_d = S_RESPOND;
            S_READ_VICTIM: state_d = S_WRITE_BACK;
            S_WRITE_BACK:  state_d = line_done ? S_REFILL : S_WRITE_BACK;
            S_REFILL:      state_d = line_done ? S_RESPOND : S_REFILL;
            default:       state_d = S_IDLE;   // respond
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // tags are read as the request is accepted, so lookup sees them next cycle
    assign tag_rd_en    = fire;
    assign tag_rd_set   = req_addr[OFS +: cache_geom_pkg::SET_W];
    assign data_rd_en   = (state_q == S_LOOKUP);     // hit bank or dirty victim line
    assign data_rd_way  = hit ? hit_way : victim_way;
    assign arr_wr_en    = (state_q == S_WRITE_HIT) || (state_q == S_REFILL && line_done);
    assign arr_wr_way   = way_q;
    assign tag_wr_dirty = is_store;

    assign bank_oh = cache_geom_pkg::bank_oh_t'(1) << store_bank;

    always_comb begin
        for (int b = 0; b < cache_geom_pkg::BANK_NUM; b++) begin
            hit_mask[b*W +: W] = bank_oh[b] ? wmask_q : '0;
        end
    end

    assign data_wr_line = (state_q == S_WRITE_HIT) ? {cache_geom_pkg::BANK_NUM{wdata_q}}
                                                   : refill_line;
    assign data_wr_mask = (state_q == S_WRITE_HIT) ? hit_mask : '1;

    // clean miss fetches straight from lookup, dirty miss writes back first
    assign mem_start  = (state_q == S_LOOKUP && !hit && !victim_dirty) ||
                        (state_q == S_READ_VICTIM) ||
                        (state_q == S_WRITE_BACK && line_done);
    assign mem_req_op = (state_q == S_READ_VICTIM) ? cache_bus_pkg::OP_WRITE
                                                   : cache_bus_pkg::OP_READ;
    assign line_addr  = (state_q == S_READ_VICTIM) ? victim_addr_q
                                                   : {addr_q[cache_geom_pkg::ADDR_W-1:OFS],
                                                      {OFS{1'b0}}};
    assign wb_line    = rd_line;

    always_ff @(posedge clock) begin
        if (fire) begin
            addr_q  <= req_addr;
            op_q    <= req_op;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
        if (state_q == S_LOOKUP) begin
            way_q         <= data_rd_way;     // hit way or the victim
            victim_addr_q <= victim_addr;
        end
        if (state_q == S_READ_HIT) begin
            resp_q <= rd_line[store_bank*W +: W];
        end else if (state_q == S_REFILL && line_done) begin
            resp_q <= refill_line[store_bank*W +: W];
        end
    end

endmodule

// File: dcache_top.sv
module dcache_top (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  req_valid,
    input  cache_bus_pkg::op_t    req_op,
    input  cache_geom_pkg::addr_t req_addr,
    input  cache_geom_pkg::word_t req_wdata,
    input  cache_geom_pkg::mask_t req_wmask,
    output logic                  req_ready,
    output logic                  resp_done,
    output cache_geom_pkg::word_t resp_rdata,
    output logic                  mem_valid,
    output cache_bus_pkg::op_t    mem_op,
    output cache_geom_pkg::addr_t mem_addr,
    output cache_geom_pkg::line_t mem_wdata,
    input  logic                  mem_ready,
    input  logic                  mem_done,
    input  cache_geom_pkg::line_t mem_rdata
);
    logic                               hit, victim_dirty, tag_rd_en, arr_wr_en;
    logic                               tag_wr_dirty, data_rd_en, mem_start, is_store;
    logic                               line_done;
    logic [cache_geom_pkg::WAY_NUM-1:0] rd_valid, rd_dirty;
    cache_geom_pkg::way_oh_t            hit_way, victim_way, arr_wr_way, data_rd_way;
    cache_geom_pkg::addr_t              victim_addr, line_addr;
    cache_geom_pkg::tag_t               req_tag, rd_tag0, rd_tag1;
    cache_geom_pkg::set_idx_t           req_set, tag_rd_set;
    cache_geom_pkg::line_t              data_wr_line, data_wr_mask, rd_line;
    cache_geom_pkg::line_t              wb_line, refill_line;
    cache_geom_pkg::bank_idx_t          store_bank;
    cache_geom_pkg::word_t              store_data;
    cache_geom_pkg::mask_t              store_mask;
    cache_bus_pkg::op_t                 mem_req_op;

    dcache_ctrl ctrl_i (.*);

    dcache_lookup lookup_i (.*);

    dcache_tag_array tag_array_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .rd_en    (tag_rd_en),
        .rd_set   (tag_rd_set),
        .wr_en    (arr_wr_en),
        .wr_set   (req_set),
        .wr_way   (arr_wr_way),
        .wr_tag   (req_tag),
        .wr_dirty (tag_wr_dirty),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .rd_tag0  (rd_tag0),
        .rd_tag1  (rd_tag1)
    );

    dcache_data_array data_array_i (
        .clock        (clock),
        .rd_en        (data_rd_en),
        .rd_set       (req_set),
        .rd_way       (data_rd_way),
        .wr_en        (arr_wr_en),
        .wr_set       (req_set),
        .wr_way       (arr_wr_way),
        .wr_line      (data_wr_line),
        .wr_mask_line (data_wr_mask),
        .rd_line      (rd_line)
    );

    dcache_mem_port mem_port_i (
        .start (mem_start),
        .op    (mem_req_op),
        .*
    );

endmodule

// File: tb_dcache_mem.sv
module tb_dcache_mem #(
    parameter cache_geom_pkg::addr_t BASE = '0,   // region base, low 15 bits zero
    parameter integer                SEED = 1
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  mem_valid,
    input  cache_bus_pkg::op_t    mem_op,
    input  cache_geom_pkg::addr_t mem_addr,
    input  cache_geom_pkg::line_t mem_wdata,
    output logic                  mem_ready,
    output logic                  mem_done,
    output cache_geom_pkg::line_t mem_rdata,
    output cache_geom_pkg::line_t stored_line    // contents at the last accepted address
);
    cache_geom_pkg::line_t lines [512];         // address bits 14..6
    cache_geom_pkg::line_t wdata_q;
    cache_bus_pkg::op_t    op_q;
    logic [8:0]            idx_q;
    logic                  busy;
    int                    delay;
    integer                seed = SEED;
    integer                rnd;

    // each word starts as a function of its own byte address
    function automatic cache_geom_pkg::word_t fill_word(input cache_geom_pkg::addr_t a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    assign stored_line = lines[idx_q];

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 512; i++) begin
                for (int b = 0; b < 8; b++) begin
                    lines[i][b*64 +: 64] <= fill_word(BASE | (i << 6) | (b << 3));
                end
            end
            mem_ready <= 1'b0;
            mem_done  <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            idx_q     <= '0;
            delay     <= 0;
        end else begin
            mem_done <= 1'b0;
            rnd = $random(seed);
            if (!busy) begin
                mem_ready <= rnd[0];             // random stall before accepting
                if (mem_valid && mem_ready) begin
                    busy      <= 1'b1;
                    mem_ready <= 1'b0;
                    op_q      <= mem_op;
                    idx_q     <= mem_addr[14:6];
                    wdata_q   <= mem_wdata;
                    delay     <= rnd[3:1] + 1;   // 1 to 8 cycles
                end
            end else if (delay > 1) begin
                delay <= delay - 1;
            end else begin
                busy     <= 1'b0;
                mem_done <= 1'b1;
                if (op_q == cache_bus_pkg::OP_WRITE) begin
                    lines[idx_q] <= wdata_q;
                end else begin
                    mem_rdata <= lines[idx_q];
                end
            end
        end
    end

endmodule

// File: tb_dcache.sv
module tb_dcache;
    localparam cache_geom_pkg::addr_t BASE = 32'h3b6a_0000;  // bits 14..0 index the model
    localparam integer                SEED = 32'h6d24cdcc;
    localparam int                    MAX_CYCLES = 20000;
    localparam int                    RANDOM_OPS = 200;

    logic                  clock;
    logic                  reset_n;
    logic                  req_valid;
    cache_bus_pkg::op_t    req_op;
    cache_geom_pkg::addr_t req_addr;
    cache_geom_pkg::word_t req_wdata;
    cache_geom_pkg::mask_t req_wmask;
    logic                  req_ready;
    logic                  resp_done;
    cache_geom_pkg::word_t resp_rdata;
    logic                  mem_valid;
    logic                  mem_ready;
    logic                  mem_done;
    cache_bus_pkg::op_t    mem_op;
    cache_geom_pkg::addr_t mem_addr;
    cache_geom_pkg::line_t mem_wdata;
    cache_geom_pkg::line_t mem_rdata;
    cache_geom_pkg::line_t stored_line;

    cache_geom_pkg::word_t model_mem [4096];     // byte address bits 14..3
    logic                  line_written [512];
    cache_geom_pkg::word_t exp_q [$];
    string                 name_q [$];
    cache_bus_pkg::op_t    bus_op_q;
    cache_geom_pkg::addr_t bus_addr_q;
    int                    cycle_count = 0;
    integer                seed = SEED;

    dcache_top dut_i (.*);

    tb_dcache_mem #(.BASE(BASE), .SEED(SEED)) mem_i (.*);

    function automatic cache_geom_pkg::word_t initial_word(input cache_geom_pkg::addr_t a);
        return {a ^ 32'h9e37_79b9, ~a};
    endfunction

    function automatic cache_geom_pkg::addr_t make_addr(input int tag, input int set,
                                                        input int bank);
        return BASE | (tag << 12) | (set << 6) | (bank << 3);
    endfunction

    // a write merges under the mask and answers zero
    function automatic cache_geom_pkg::word_t expected_response(
        input cache_bus_pkg::op_t op, input cache_geom_pkg::addr_t a,
        input cache_geom_pkg::word_t wdata, input cache_geom_pkg::mask_t wmask);
        int i;
        i = a[14:3];
        if (op == cache_bus_pkg::OP_READ) begin
            return model_mem[i];
        end
        model_mem[i] = (model_mem[i] & ~wmask) | (wdata & wmask);
        line_written[a[14:6]] = 1'b1;
        return '0;
    endfunction

    function automatic cache_geom_pkg::line_t model_line(input cache_geom_pkg::addr_t a);
        cache_geom_pkg::line_t l;
        for (int b = 0; b < 8; b++) begin
            l[b*64 +: 64] = model_mem[a[14:6] * 8 + b];   // bank 0 lowest
        end
        return l;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input cache_geom_pkg::word_t exp,
                              input cache_geom_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input cache_geom_pkg::line_t exp,
                              input cache_geom_pkg::line_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // one request, queued expectation, then wait for its response
    task automatic run_request(input string name, input cache_bus_pkg::op_t op,
                               input cache_geom_pkg::addr_t a,
                               input cache_geom_pkg::word_t wdata,
                               input cache_geom_pkg::mask_t wmask);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= a;
        req_wdata <= wdata;
        req_wmask <= wmask;
        do begin
            @(posedge clock);
        end while (!req_ready);
        exp_q.push_back(expected_response(op, a, wdata, wmask));
        name_q.push_back(name);
        req_valid <= 1'b0;
        do begin
            @(posedge clock);
        end while (!resp_done);
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        abort_run("timeout, the run did not finish within the cycle limit");
    end

    // compare every response against the queued expectation
    always @(posedge clock) begin
        if (resp_done) begin
            if (exp_q.size() == 0) begin
                abort_run("resp_done pulsed with no request outstanding");
            end else begin
                check_word(name_q.pop_front(), exp_q.pop_front(), resp_rdata);
            end
        end
    end

    // a finished write-back leaves the model's line in memory
    always @(posedge clock) begin
        if (mem_valid && mem_ready) begin
            if (mem_addr[31:15] != BASE[31:15] || mem_addr[5:0] != '0) begin
                abort_run("memory request outside the modeled region or not line aligned");
            end else begin
                bus_op_q   <= mem_op;
                bus_addr_q <= mem_addr;
            end
        end
        if (mem_done && bus_op_q == cache_bus_pkg::OP_WRITE) begin
            check_line("write-back", model_line(bus_addr_q), stored_line);
        end
    end

    initial begin : stimulus
        cache_geom_pkg::addr_t a;
        cache_geom_pkg::word_t wdata;
        cache_geom_pkg::mask_t wmask;
        cache_bus_pkg::op_t    op;
        integer                r;
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req_op    = cache_bus_pkg::OP_READ;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        for (int i = 0; i < 4096; i++) begin
            model_mem[i] = initial_word(BASE | (i << 3));
        end
        for (int i = 0; i < 512; i++) begin
            line_written[i] = 1'b0;
        end
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        check_flag("after reset req_ready", 1'b1, req_ready);
        check_flag("after reset mem_valid", 1'b0, mem_valid);
        check_flag("after reset resp_done", 1'b0, resp_done);

        run_request("cold read", cache_bus_pkg::OP_READ, make_addr(5, 40, 3), '0, '0);

        a = make_addr(5, 41, 2);                 // write miss, then write hit
        run_request("write miss", cache_bus_pkg::OP_WRITE, a,
                    64'h0123_4567_89ab_cdef, 64'h00ff_f0f0_0000_ffff);
        run_request("read after write miss", cache_bus_pkg::OP_READ, a, '0, '0);
        run_request("write hit", cache_bus_pkg::OP_WRITE, a,
                    64'hfedc_ba98_7654_3210, 64'hff00_0000_ffff_0f0f);
        run_request("read after write hit", cache_bus_pkg::OP_READ, a, '0, '0);

        // three tags in one two-way set
        for (int t = 4; t < 7; t++) begin
            wdata = {$random(seed), $random(seed)};
            run_request("conflict write", cache_bus_pkg::OP_WRITE, make_addr(t, 50, t),
                        wdata, '1);
        end
        for (int t = 4; t < 7; t++) begin
            run_request("conflict read", cache_bus_pkg::OP_READ, make_addr(t, 50, t), '0, '0);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r     = $random(seed);
            op    = cache_bus_pkg::op_t'(r[0]);
            a     = make_addr(r[2:1], r[6:3], r[9:7]);   // 4 tags x 16 sets
            wdata = {$random(seed), $random(seed)};
            wmask = {$random(seed), $random(seed)};
            run_request($sformatf("random %0d", n), op, a, wdata, wmask);
        end

        for (int i = 0; i < 512; i++) begin
            if (line_written[i]) begin
                for (int b = 0; b < 8; b++) begin
                    a = BASE | (i << 6) | (b << 3);
                    run_request($sformatf("reread %h", a), cache_bus_pkg::OP_READ, a, '0, '0);
                end
            end
        end

        @(posedge clock);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: files.f
cache_geom_pkg.sv
cache_bus_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_lookup.sv
dcache_mem_port.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - cache_geom_pkg.sv
  - cache_bus_pkg.sv
  - dcache_tag_array.sv
  - dcache_data_array.sv
  - dcache_lookup.sv
  - dcache_mem_port.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache_mem.sv
      - tb_dcache.sv
